// File: filelist.f
src/periph_pkg.sv
src/periph_bus_control.sv
src/config_ram.sv
src/timebase.sv
src/gamepad_reader.sv
src/periph_top.sv
test/periph_asserts.sv
test/periph_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= periph_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove build output and log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "Regression passed" $(LOG) || (echo "FAIL"; exit 1)
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/periph_tb.sv
// Peripheral block testbench: AXI-Lite master, controller models, reference checks
`timescale 1ns/1ps

module periph_tb import periph_pkg::*; ();

	localparam int TICK_DIV = 8;
	localparam int POLL_CYCLES = (2 + 2 * PAD_BITS) * TICK_DIV;
	localparam int PLANNED_TXNS = 130;
	localparam logic [31:0] SEED = 32'hf6ea_16c5;

	logic clk_50mhz, resetn;
	addr_t awaddr, araddr;
	data_t wdata, rdata;
	strb_t wstrb;
	resp_t bresp, rresp;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic pad0_clk, pad0_latch, pad0_data, pad1_clk, pad1_latch, pad1_data;
	buttons_t pad0_value, pad1_value;
	data_t shadow [256];
	bit written [256];
	longint cycles;

	periph_top #(.PAD_TICK_DIV(TICK_DIV)) periph_top_inst (.*);

	pad_model pad0_model (.clk_50mhz, .pad_clk(pad0_clk), .pad_latch(pad0_latch),
		.value(pad0_value), .pad_data(pad0_data));
	pad_model pad1_model (.clk_50mhz, .pad_clk(pad1_clk), .pad_latch(pad1_latch),
		.value(pad1_value), .pad_data(pad1_data));

	bind periph_bus_control periph_asserts bus_checks (.clk_50mhz, .resetn, .rvalid, .rready,
		.arvalid, .arready, .bvalid, .bready, .pad_clk(1'b0), .pad_latch(1'b0));
	bind gamepad_reader periph_asserts pad_checks (.clk_50mhz, .resetn, .rvalid(1'b0),
		.rready(1'b0), .arvalid(1'b0), .arready(1'b0), .bvalid(1'b0), .bready(1'b0),
		.pad_clk, .pad_latch);

	initial begin
		clk_50mhz = 1'b0;
		forever #10 clk_50mhz = ~clk_50mhz;
	end

	always @(posedge clk_50mhz) cycles <= cycles + 1;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_data(input data_t got, input data_t exp, input string what);
		if (got !== exp)
			fail_run($sformatf("error at %0t ns: %s data %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_resp(input resp_t got, input resp_t exp, input string what);
		if (got !== exp)
			fail_run($sformatf("error at %0t ns: %s resp %0d, expected %0d", $time, what, got, exp));
	endtask

	function automatic bit in_window(input addr_t addr, input addr_t base, input int bits);
		return (addr & ~((addr_t'(1) << bits) - 1)) == base;
	endfunction

	// Expected read from the region map and the shadow memory
	function automatic data_t expected_read(input addr_t addr, input data_t counter_val,
		output resp_t resp);
		resp = RESP_OKAY;
		if (in_window(addr, CONFIG_BASE, CONFIG_ADDR_BITS)) return shadow[addr[9:2]];
		if (in_window(addr, COUNTER_BASE, COUNTER_ADDR_BITS)) return counter_val;
		if (in_window(addr, PAD_BASE, PAD_ADDR_BITS)) return {16'h0, pad1_value, pad0_value};
		resp = RESP_DECERR;
		return '0;
	endfunction

	function automatic resp_t expected_write_resp(input addr_t addr);
		if (in_window(addr, CONFIG_BASE, CONFIG_ADDR_BITS)) return RESP_OKAY;
		if (in_window(addr, COUNTER_BASE, COUNTER_ADDR_BITS)) return RESP_SLVERR;
		if (in_window(addr, PAD_BASE, PAD_ADDR_BITS)) return RESP_SLVERR;
		return RESP_DECERR;
	endfunction

	task automatic write_txn(input addr_t a, input data_t d, input strb_t s, output resp_t resp);
		@(posedge clk_50mhz);
		awaddr <= a;
		wdata <= d;
		wstrb <= s;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		do @(negedge clk_50mhz); while (!(awready && wready));
		@(posedge clk_50mhz);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		repeat ($urandom_range(0, 4)) @(posedge clk_50mhz);
		bready <= 1'b1;
		do @(negedge clk_50mhz); while (!bvalid);
		resp = bresp;
		@(posedge clk_50mhz);
		bready <= 1'b0;
	endtask

	// Stalls rready, checking that the response holds and no read is accepted
	task automatic read_txn(input addr_t a, output data_t d, output resp_t resp,
		output longint hs_cycle);
		@(posedge clk_50mhz);
		araddr <= a;
		arvalid <= 1'b1;
		do @(negedge clk_50mhz); while (!arready);
		@(posedge clk_50mhz);
		arvalid <= 1'b0;
		hs_cycle = cycles;
		@(negedge clk_50mhz);
		if (!rvalid) fail_run("rvalid did not rise one cycle after the address handshake");
		d = rdata;
		resp = rresp;
		repeat ($urandom_range(0, 8)) begin
			@(negedge clk_50mhz);
			if (!rvalid || arready) fail_run("read response dropped or second read accepted");
			check_data(rdata, d, "stalled read");
			check_resp(rresp, resp, "stalled read");
		end
		@(posedge clk_50mhz);
		rready <= 1'b1;
		@(negedge clk_50mhz);
		check_data(rdata, d, "stalled read");
		@(posedge clk_50mhz);
		rready <= 1'b0;
	endtask

	task automatic wait_two_polls();
		repeat (2) begin
			do @(negedge clk_50mhz); while (!(pad0_latch && pad1_latch));
			do @(negedge clk_50mhz); while (pad0_latch || pad1_latch);
		end
	endtask

	initial begin
		#(longint'(PLANNED_TXNS) * POLL_CYCLES * 20 + 20000);
		fail_run("watchdog timeout, the run did not finish in time");
	end

	initial begin
		int idx;
		addr_t a;
		data_t d, got, exp, first;
		resp_t resp, eresp;
		strb_t s;
		longint hs0, hs1;
		addr_t unmapped [4];
		unmapped = '{32'h0200_0000, 32'h0200_0204, 32'h0200_0800, 32'h8000_0000};
		void'($urandom(SEED));
		resetn = 1'b0;
		{awaddr, araddr, wdata, wstrb} = '0;
		{awvalid, wvalid, bready, arvalid, rready} = '0;
		pad0_value = '0;
		pad1_value = '0;
		repeat (10) @(posedge clk_50mhz);
		resetn <= 1'b1;

		// Config memory, odd passes revisit the last word with partial strobes
		for (int n = 0; n < 48; n++) begin
			if (n % 2 == 0)
				idx = $urandom_range(0, 255);
			a = CONFIG_BASE + addr_t'(idx * 4);
			d = $urandom();
			s = written[idx] ? strb_t'($urandom_range(1, 14)) : 4'hf;
			write_txn(a, d, s, resp);
			check_resp(resp, RESP_OKAY, "config write");
			for (int b = 0; b < 4; b++)
				if (s[b]) shadow[idx][8*b +: 8] = d[8*b +: 8];
			written[idx] = 1'b1;
			read_txn(a, got, resp, hs0);
			exp = expected_read(a, '0, eresp);
			check_data(got, exp, "config read");
			check_resp(resp, eresp, "config read");
		end

		// Counter
		read_txn(COUNTER_BASE, first, resp, hs0);
		check_resp(resp, RESP_OKAY, "counter read");
		repeat ($urandom_range(1, 20)) @(posedge clk_50mhz);
		read_txn(COUNTER_BASE + 4, got, resp, hs1);
		exp = expected_read(COUNTER_BASE + 4, first + data_t'(hs1 - hs0), eresp);
		check_data(got, exp, "counter read");
		check_resp(resp, eresp, "counter read");
		write_txn(COUNTER_BASE, $urandom(), 4'hf, resp);
		check_resp(resp, expected_write_resp(COUNTER_BASE), "counter write");

		// Gamepads
		repeat (2) begin
			@(posedge clk_50mhz);
			pad0_value <= buttons_t'($urandom());
			pad1_value <= buttons_t'($urandom());
			wait_two_polls();
			read_txn(PAD_BASE, got, resp, hs0);
			exp = expected_read(PAD_BASE, '0, eresp);
			check_data(got, exp, "pad read");
			check_resp(resp, eresp, "pad read");
		end
		write_txn(PAD_BASE, $urandom(), 4'hf, resp);
		check_resp(resp, expected_write_resp(PAD_BASE), "pad write");

		// Unmapped addresses
		foreach (unmapped[i]) begin
			read_txn(unmapped[i], got, resp, hs0);
			exp = expected_read(unmapped[i], '0, eresp);
			check_data(got, exp, "unmapped read");
			check_resp(resp, eresp, "unmapped read");
			write_txn(unmapped[i], $urandom(), 4'hf, resp);
			check_resp(resp, expected_write_resp(unmapped[i]), "unmapped write");
		end

		$display("Regression passed");
		$finish;
	end

endmodule

// Serial controller shift register, low-active data, shifts on clock rise
module pad_model import periph_pkg::*; (
	input  logic     clk_50mhz,
	input  logic     pad_clk,
	input  logic     pad_latch,
	input  buttons_t value,
	output logic     pad_data
);

	buttons_t sr = '0;
	logic clk_q = 1'b0;

	always @(posedge clk_50mhz) begin
		clk_q <= pad_clk;
		if (pad_latch) sr <= value;
		else if (pad_clk && !clk_q) sr <= sr >> 1;
	end

	assign pad_data = ~sr[0];

endmodule

// File: test/periph_asserts.sv
// Bus handshake and pad pin protocol assertions
`timescale 1ns/1ps

module periph_asserts (
	input logic clk_50mhz,
	input logic resetn,
	input logic rvalid,
	input logic rready,
	input logic arvalid,
	input logic arready,
	input logic bvalid,
	input logic bready,
	input logic pad_clk,
	input logic pad_latch
);

	rvalid_hold: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

	bvalid_hold: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	// One read in flight, answered the cycle after its address handshake
	ar_blocked: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		arvalid && arready |=> rvalid && !arready)
		else $error("read not answered or a second read accepted after the handshake");

	pad_pins: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		!(pad_latch && pad_clk))
		else $error("pad latch and clock high together");

endmodule

// File: src/periph_top.sv
// Peripheral block top: AXI-Lite control, config memory, timebase and two gamepads
`timescale 1ns/1ps

module periph_top import periph_pkg::*; #(
	parameter int CONFIG_DEPTH = 256,
	parameter int PAD_TICK_DIV = 512
) (
	input  logic  clk_50mhz,
	input  logic  resetn,
	input  addr_t awaddr,
	input  logic  awvalid,
	output logic  awready,
	input  data_t wdata,
	input  strb_t wstrb,
	input  logic  wvalid,
	output logic  wready,
	output resp_t bresp,
	output logic  bvalid,
	input  logic  bready,
	input  addr_t araddr,
	input  logic  arvalid,
	output logic  arready,
	output data_t rdata,
	output resp_t rresp,
	output logic  rvalid,
	input  logic  rready,
	output logic  pad0_clk,
	output logic  pad0_latch,
	input  logic  pad0_data,
	output logic  pad1_clk,
	output logic  pad1_latch,
	input  logic  pad1_data
);

	logic                            cfg_we;
	logic [$clog2(CONFIG_DEPTH)-1:0] cfg_index;
	data_t                           cfg_wdata;
	strb_t                           cfg_wstrb;
	data_t                           cfg_rdata;
	data_t                           cycle_count;
	logic                            poll_tick;
	buttons_t                        pad0_buttons;
	buttons_t                        pad1_buttons;

	periph_bus_control #(
		.CONFIG_DEPTH(CONFIG_DEPTH)
	) periph_bus_control_inst (
		.clk_50mhz   (clk_50mhz),
		.resetn      (resetn),
		.awaddr      (awaddr),
		.awvalid     (awvalid),
		.awready     (awready),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.wvalid      (wvalid),
		.wready      (wready),
		.bresp       (bresp),
		.bvalid      (bvalid),
		.bready      (bready),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.arready     (arready),
		.rdata       (rdata),
		.rresp       (rresp),
		.rvalid      (rvalid),
		.rready      (rready),
		.cfg_we      (cfg_we),
		.cfg_index   (cfg_index),
		.cfg_wdata   (cfg_wdata),
		.cfg_wstrb   (cfg_wstrb),
		.cfg_rdata   (cfg_rdata),
		.cycle_count (cycle_count),
		.pad0_buttons(pad0_buttons),
		.pad1_buttons(pad1_buttons)
	);

	config_ram #(
		.CONFIG_DEPTH(CONFIG_DEPTH)
	) config_ram_inst (
		.clk_50mhz(clk_50mhz),
		.cfg_we   (cfg_we),
		.cfg_index(cfg_index),
		.cfg_wdata(cfg_wdata),
		.cfg_wstrb(cfg_wstrb),
		.cfg_rdata(cfg_rdata)
	);

	timebase #(
		.PAD_TICK_DIV(PAD_TICK_DIV)
	) timebase_inst (
		.clk_50mhz  (clk_50mhz),
		.resetn     (resetn),
		.cycle_count(cycle_count),
		.poll_tick  (poll_tick)
	);

	gamepad_reader gamepad_reader_0 (
		.clk_50mhz(clk_50mhz),
		.resetn   (resetn),
		.poll_tick(poll_tick),
		.pad_clk  (pad0_clk),
		.pad_latch(pad0_latch),
		.pad_data (pad0_data),
		.buttons  (pad0_buttons)
	);

	gamepad_reader gamepad_reader_1 (
		.clk_50mhz(clk_50mhz),
		.resetn   (resetn),
		.poll_tick(poll_tick),
		.pad_clk  (pad1_clk),
		.pad_latch(pad1_latch),
		.pad_data (pad1_data),
		.buttons  (pad1_buttons)
	);

endmodule

// File: src/gamepad_reader.sv
// Serial controller poll: latch, clock out the shift register, publish a button byte
`timescale 1ns/1ps

module gamepad_reader import periph_pkg::*; (
	input  logic     clk_50mhz,
	input  logic     resetn,
	input  logic     poll_tick,
	output logic     pad_clk,
	output logic     pad_latch,
	input  logic     pad_data,
	output buttons_t buttons
);

	// Step 0 latches, odd steps sample, even steps raise the clock
	localparam int LAST_STEP = 2 * PAD_BITS + 1;
	localparam int STEP_BITS = $clog2(LAST_STEP + 1);
	localparam logic [STEP_BITS-1:0] STEP_LAST = STEP_BITS'(LAST_STEP);

	logic [STEP_BITS-1:0] step;
	logic [STEP_BITS-1:0] step_next;
	buttons_t             shift_q;

	assign step_next = (step == STEP_LAST) ? '0 : step + 1'b1;

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			// Next tick starts a fresh poll
			step      <= STEP_LAST;
			pad_latch <= 1'b0;
			pad_clk   <= 1'b0;
			shift_q   <= '0;
			buttons   <= '0;
		end else if (poll_tick) begin
			step      <= step_next;
			pad_latch <= step_next == '0;
			pad_clk   <= !step_next[0] && step_next != '0;

			// Low-active line, bit 0 arrives first
			if (step[0] && (step >> 1) < PAD_BITS) begin
				shift_q <= {~pad_data, shift_q[PAD_BITS-1:1]};
			end

			if (step == STEP_LAST) begin
				buttons <= shift_q;
			end
		end
	end

endmodule

// File: src/timebase.sv
// System cycle counter and gamepad poll step divider
`timescale 1ns/1ps

module timebase import periph_pkg::*; #(
	parameter int PAD_TICK_DIV = 512
) (
	input  logic  clk_50mhz,
	input  logic  resetn,
	output data_t cycle_count,
	output logic  poll_tick
);

	localparam int DIV_BITS = $clog2(PAD_TICK_DIV);
	localparam logic [DIV_BITS-1:0] DIV_LAST = DIV_BITS'(PAD_TICK_DIV - 1);

	logic [DIV_BITS-1:0] div_count;

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			cycle_count <= '0;
			div_count   <= '0;
		end else begin
			cycle_count <= cycle_count + 1'b1;
			div_count   <= poll_tick ? '0 : div_count + 1'b1;
		end
	end

	// One cycle per PAD_TICK_DIV
	assign poll_tick = div_count == DIV_LAST;

endmodule

// File: src/config_ram.sv
// Configuration memory, word addressed, byte-strobe writes and registered read
`timescale 1ns/1ps

module config_ram import periph_pkg::*; #(
	parameter int CONFIG_DEPTH = 256
) (
	input  logic                            clk_50mhz,
	input  logic                            cfg_we,
	input  logic [$clog2(CONFIG_DEPTH)-1:0] cfg_index,
	input  data_t                           cfg_wdata,
	input  strb_t                           cfg_wstrb,
	output data_t                           cfg_rdata
);

	data_t mem [CONFIG_DEPTH];

	always_ff @(posedge clk_50mhz) begin
		if (cfg_we) begin
			for (int i = 0; i < $bits(strb_t); i++) begin
				if (cfg_wstrb[i]) begin
					mem[cfg_index][8*i +: 8] <= cfg_wdata[8*i +: 8];
				end
			end
		end
		// Old contents on a same-cycle write
		cfg_rdata <= mem[cfg_index];
	end

endmodule

// File: src/periph_bus_control.sv
// AXI-Lite slave control: handshakes, region decode, responses and read data selection
`timescale 1ns/1ps

module periph_bus_control import periph_pkg::*; #(
	parameter int CONFIG_DEPTH = 256
) (
	input  logic                            clk_50mhz,
	input  logic                            resetn,
	input  addr_t                           awaddr,
	input  logic                            awvalid,
	output logic                            awready,
	input  data_t                           wdata,
	input  strb_t                           wstrb,
	input  logic                            wvalid,
	output logic                            wready,
	output resp_t                           bresp,
	output logic                            bvalid,
	input  logic                            bready,
	input  addr_t                           araddr,
	input  logic                            arvalid,
	output logic                            arready,
	output data_t                           rdata,
	output resp_t                           rresp,
	output logic                            rvalid,
	input  logic                            rready,
	output logic                            cfg_we,
	output logic [$clog2(CONFIG_DEPTH)-1:0] cfg_index,
	output data_t                           cfg_wdata,
	output strb_t                           cfg_wstrb,
	input  data_t                           cfg_rdata,
	input  data_t                           cycle_count,
	input  buttons_t                        pad0_buttons,
	input  buttons_t                        pad1_buttons
);

	localparam int INDEX_BITS = $clog2(CONFIG_DEPTH);

	typedef enum logic [1:0] {
		REGION_NONE,
		REGION_CONFIG,
		REGION_COUNTER,
		REGION_PAD
	} region_t;

	function automatic region_t decode(input addr_t addr);
		region_t region;
		if ((addr >> CONFIG_ADDR_BITS) == (CONFIG_BASE >> CONFIG_ADDR_BITS)) begin
			region = REGION_CONFIG;
		end else if ((addr >> COUNTER_ADDR_BITS) == (COUNTER_BASE >> COUNTER_ADDR_BITS)) begin
			region = REGION_COUNTER;
		end else if ((addr >> PAD_ADDR_BITS) == (PAD_BASE >> PAD_ADDR_BITS)) begin
			region = REGION_PAD;
		end else begin
			region = REGION_NONE;
		end
		return region;
	endfunction

	region_t ar_region;
	region_t aw_region;
	region_t rd_region_q;
	logic    ar_hs;
	logic    wr_go;
	logic    rd_first_q;
	data_t   rd_data_q;

	assign ar_region = decode(araddr);
	assign aw_region = decode(awaddr);

	// One read in flight
	assign arready = !rvalid;
	assign ar_hs   = arvalid && arready;

	// A config write yields the RAM port to a config read in the same cycle
	assign wr_go = awvalid && wvalid && !bvalid &&
		!(ar_hs && ar_region == REGION_CONFIG && aw_region == REGION_CONFIG);
	assign awready = wr_go;
	assign wready  = wr_go;

	assign cfg_we    = wr_go && aw_region == REGION_CONFIG;
	assign cfg_index = cfg_we ? awaddr[2 +: INDEX_BITS] : araddr[2 +: INDEX_BITS];
	assign cfg_wdata = wdata;
	assign cfg_wstrb = wstrb;

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			rvalid     <= 1'b0;
			rd_first_q <= 1'b0;
			bvalid     <= 1'b0;
		end else begin
			rd_first_q <= ar_hs;
			if (ar_hs) begin
				rvalid <= 1'b1;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
			if (wr_go) begin
				bvalid <= 1'b1;
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// Counter and pads are sampled at the address handshake
	always_ff @(posedge clk_50mhz) begin
		if (ar_hs) begin
			rd_region_q <= ar_region;
			rresp       <= (ar_region == REGION_NONE) ? RESP_DECERR : RESP_OKAY;
			case (ar_region)
				REGION_COUNTER: rd_data_q <= cycle_count;
				REGION_PAD:     rd_data_q <= {16'h0000, pad1_buttons, pad0_buttons};
				default:        rd_data_q <= '0;
			endcase
		end else if (rd_first_q && rd_region_q == REGION_CONFIG) begin
			// Keep the RAM word for a stalled response
			rd_data_q <= cfg_rdata;
		end
	end

	assign rdata = (rd_first_q && rd_region_q == REGION_CONFIG) ? cfg_rdata : rd_data_q;

	always_ff @(posedge clk_50mhz) begin
		if (wr_go) begin
			case (aw_region)
				REGION_CONFIG:  bresp <= RESP_OKAY;
				REGION_COUNTER: bresp <= RESP_SLVERR;
				REGION_PAD:     bresp <= RESP_SLVERR;
				default:        bresp <= RESP_DECERR;
			endcase
		end
	end

endmodule

// File: src/periph_pkg.sv
// Peripheral block shared types, region map and AXI-Lite response codes
package periph_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;
	typedef logic [1:0]  resp_t;

	localparam resp_t RESP_OKAY   = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;
	localparam resp_t RESP_DECERR = 2'd3;

	// Config memory, 1 KiB window
	localparam addr_t CONFIG_BASE       = 32'h0200_0400;
	localparam int    CONFIG_ADDR_BITS  = 10;

	// Free-running system counter
	localparam addr_t COUNTER_BASE      = 32'h0200_0300;
	localparam int    COUNTER_ADDR_BITS = 8;

	// Gamepad button word
	localparam addr_t PAD_BASE          = 32'h0200_0200;
	localparam int    PAD_ADDR_BITS     = 2;

	// Bit 0 is shifted out first, 1 means pressed
	typedef logic [7:0] buttons_t;
	localparam int PAD_BITS = 8;

endpackage
